// ==== lsu_iq.f ====
+incdir+hw
hw/lsu_iq_pkg.sv
hw/lsu_iq_alloc.sv
hw/iq_entry.sv
hw/lsu_iq_issue.sv
hw/lsu_iq.sv
verification/lsu_iq_sva.sv
verification/lsu_iq_tb.sv

// ==== verification/lsu_iq_tb.sv ====
`include "lsu_iq_consts.svh"

module lsu_iq_tb
    import lsu_iq_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NROWS = 20;

    typedef struct packed {
        mem_op_e   op;
        mem_size_e size;
        word_t     imm;
        rob_id_t   rob;
        word_t     d0;
        word_t     d1;
        logic      rdy0;
        logic      rdy1;
        rob_id_t   tag0;
        rob_id_t   tag1;
        int        dly;
        bit        pair;
        bit        flush;
        bit        hold;
    } row_t;

    logic clk = 0;
    logic arst_n_i = 0;
    logic flush_i = 0;
    logic req_ready_i;
    logic ready_rand = 0;
    logic [1:0] disp_valid_i = '0;
    mem_op_e disp_op_i [2] = '{MEM_LOAD, MEM_LOAD};
    mem_size_e disp_size_i [2] = '{SIZE_WORD, SIZE_WORD};
    word_t disp_imm_i [2] = '{0, 0};
    rob_id_t disp_rob_id_i [2] = '{0, 0};
    word_t src_data_i [2][2] = '{'{0, 0}, '{0, 0}};
    rob_id_t src_tag_i [2][2] = '{'{0, 0}, '{0, 0}};
    logic src_rdy_i [2][2] = '{'{0, 0}, '{0, 0}};
    logic [`LSU_CDB_COUNT-1:0] cdb_valid_i = '0;
    rob_id_t cdb_tag_i [`LSU_CDB_COUNT] = '{0, 0};
    word_t cdb_data_i [`LSU_CDB_COUNT] = '{0, 0};
    logic disp_ready_o;
    logic req_valid_o;
    mem_op_e req_op_o;
    mem_size_e req_size_o;
    word_t req_vaddr_o;
    word_t req_wdata_o;
    byte_mask_t req_strb_o;
    byte_mask_t req_rmask_o;
    rob_id_t req_rob_id_o;

    row_t tbl [NROWS];
    int exp_q [$];
    bit sent [NROWS];
    int errors = 0;
    int checks = 0;
    int r = 0;
    bit hold = 0;
    bit seen_full = 0;
    bit stalled = 0;
    logic [31:0] lcg = 32'ha3a46a5b;
    word_t held_vaddr;
    rob_id_t held_rob;

    lsu_iq lsu_iq_inst (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic byte_mask_t lane_mask(input mem_size_e sz, input logic [1:0] a);
        if (sz == SIZE_BYTE) return 4'b0001 << a;
        if (sz == SIZE_HALF) return a[1] ? 4'b1100 : 4'b0011;
        return 4'b1111;
    endfunction

    task automatic fail_msg(input string msg);
        errors++;
        $display("[FAIL] %0t %s", $time, msg);
    endtask

    // ready held low while the queue fills or flushes
    assign req_ready_i = ready_rand && !hold && !flush_i;

    // ready about three cycles in four
    always @(negedge clk) begin
        lcg = lcg_next(lcg);
        ready_rand = (lcg[17:16] != 2'b00);
    end

    // --------------------
    // request monitor
    always @(posedge clk) begin
        int e;
        word_t va;
        byte_mask_t m;
        if (stalled && req_valid_o) begin
            checks++;
            if (req_vaddr_o != held_vaddr || req_rob_id_o != held_rob)
                fail_msg("stalled request changed");
        end
        stalled = req_valid_o && !req_ready_i;
        held_vaddr = req_vaddr_o;
        held_rob = req_rob_id_o;
        if (req_valid_o && req_ready_i) begin
            checks++;
            if (exp_q.size() == 0) begin
                fail_msg($sformatf("unexpected request rob %0d", req_rob_id_o));
            end else begin
                e = exp_q.pop_front();
                va = tbl[e].d1 + tbl[e].imm;
                m = lane_mask(tbl[e].size, va[1:0]);
                if (req_rob_id_o != tbl[e].rob || req_op_o != tbl[e].op
                    || req_size_o != tbl[e].size)
                    fail_msg($sformatf("row %0d got rob %0d", e, req_rob_id_o));
                if (req_vaddr_o != va)
                    fail_msg($sformatf("row %0d vaddr %h exp %h", e, req_vaddr_o, va));
                if (req_wdata_o != tbl[e].d0)
                    fail_msg($sformatf("row %0d wdata %h", e, req_wdata_o));
                if (req_strb_o != (tbl[e].op == MEM_STORE ? m : 4'b0000)
                    || req_rmask_o != (tbl[e].op == MEM_LOAD ? m : 4'b0000))
                    fail_msg($sformatf("row %0d byte masks wrong", e));
                if (tbl[e].dly > 0 && !sent[e])
                    fail_msg($sformatf("row %0d issued before its CDB broadcast", e));
            end
        end
    end

    task automatic load_slot(input int s, input int k);
        disp_op_i[s] = tbl[k].op;
        disp_size_i[s] = tbl[k].size;
        disp_imm_i[s] = tbl[k].imm;
        disp_rob_id_i[s] = tbl[k].rob;
        src_data_i[s] = '{tbl[k].rdy0 ? tbl[k].d0 : 0, tbl[k].rdy1 ? tbl[k].d1 : 0};
        src_tag_i[s] = '{tbl[k].tag0, tbl[k].tag1};
        src_rdy_i[s] = '{tbl[k].rdy0, tbl[k].rdy1};
    endtask

    task automatic broadcast(input int k);
        repeat (tbl[k].dly - 1) @(negedge clk);
        cdb_valid_i = {!tbl[k].rdy1, !tbl[k].rdy0};
        cdb_tag_i = '{tbl[k].tag0, tbl[k].tag1};
        cdb_data_i = '{tbl[k].d0, tbl[k].d1};
        sent[k] = 1;
        @(negedge clk);
        cdb_valid_i = '0;
    endtask

    initial begin
        #(NROWS * 40 * 10);
        $display("timeout, the queue stopped issuing requests");
        $display("tests failed");
        $finish;
    end

    initial begin
        // op size imm rob d0 d1 rdy0 rdy1 tag0 tag1 dly pair flush hold
        tbl = '{
            '{MEM_STORE, SIZE_WORD, 4, 1, 32'haabb0011, 32'h1000, 1, 1, 0, 0, 0, 1, 0, 0},
            '{MEM_LOAD,  SIZE_BYTE, 1, 2, 0, 32'h2000, 1, 1, 0, 0, 0, 0, 0, 0},
            '{MEM_LOAD,  SIZE_HALF, 2, 3, 0, 32'h3000, 1, 1, 0, 0, 0, 0, 0, 0},
            '{MEM_STORE, SIZE_BYTE, 3, 4, 32'h55, 32'h4000, 1, 0, 0, 40, 3, 1, 0, 0},
            '{MEM_LOAD,  SIZE_WORD, 8, 5, 0, 32'h5000, 1, 1, 0, 0, 0, 0, 0, 0},
            '{MEM_STORE, SIZE_HALF, 0, 6, 32'hbeef, 32'h6002, 0, 1, 41, 0, 2, 0, 0, 0},
            '{MEM_LOAD,  SIZE_BYTE, 2, 7, 0, 32'h7000, 1, 1, 0, 0, 0, 1, 0, 1},
            '{MEM_STORE, SIZE_WORD, 0, 8, 32'h8, 32'h8000, 1, 1, 0, 0, 0, 0, 0, 1},
            '{MEM_LOAD,  SIZE_HALF, 0, 9, 0, 32'h9000, 1, 1, 0, 0, 0, 1, 0, 1},
            '{MEM_STORE, SIZE_BYTE, 1, 10, 32'ha, 32'ha000, 1, 1, 0, 0, 0, 0, 0, 1},
            '{MEM_LOAD,  SIZE_WORD, 4, 11, 0, 32'hb000, 1, 1, 0, 0, 0, 1, 0, 1},
            '{MEM_STORE, SIZE_HALF, 2, 12, 32'hc, 32'hc000, 1, 1, 0, 0, 0, 0, 0, 1},
            '{MEM_LOAD,  SIZE_BYTE, 3, 13, 0, 32'hd000, 1, 1, 0, 0, 0, 1, 0, 1},
            '{MEM_STORE, SIZE_WORD, 0, 14, 32'he, 32'he000, 1, 1, 0, 0, 0, 0, 0, 1},
            '{MEM_LOAD,  SIZE_WORD, 0, 15, 0, 32'hf000, 1, 1, 0, 0, 0, 0, 0, 1},
            '{MEM_STORE, SIZE_BYTE, 2, 16, 32'h10, 32'h10000, 1, 1, 0, 0, 0, 1, 0, 1},
            '{MEM_LOAD,  SIZE_HALF, 2, 17, 0, 32'h11000, 1, 1, 0, 0, 0, 0, 0, 1},
            '{MEM_LOAD,  SIZE_BYTE, 1, 18, 0, 32'h12000, 1, 1, 0, 0, 0, 1, 1, 0},
            '{MEM_STORE, SIZE_WORD, 0, 19, 32'h13, 32'h13000, 1, 1, 0, 0, 0, 0, 0, 0},
            '{MEM_STORE, SIZE_HALF, 6, 20, 32'h14, 32'h14000, 1, 1, 0, 0, 0, 0, 0, 0}
        };
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1;
        @(negedge clk);
        checks++;
        if (req_valid_o || !disp_ready_o)
            fail_msg("wrong request or ready level after reset");

        while (r < NROWS) begin
            int n;
            // queue flush drops everything held so far
            if (tbl[r].flush) begin
                flush_i = 1;
                hold = 0;
                exp_q.delete();
                @(negedge clk);
                flush_i = 0;
            end
            while (!disp_ready_o) begin
                seen_full = 1;
                hold = 0;
                @(negedge clk);
            end
            hold = tbl[r].hold;
            n = tbl[r].pair ? 2 : 1;
            if (n == 2) begin
                load_slot(0, r);
                load_slot(1, r + 1);
                disp_valid_i = 2'b11;
            end else begin
                load_slot(1, r);
                disp_valid_i = 2'b10;
            end
            for (int k = r; k < r + n; k++)
                exp_q.push_back(k);
            @(negedge clk);
            disp_valid_i = '0;
            for (int k = r; k < r + n; k++)
                if (tbl[k].dly > 0)
                    broadcast(k);
            r += n;
        end
        hold = 0;
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);
        checks++;
        if (!seen_full)
            fail_msg("disp_ready_o never dropped with a full queue");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verification/lsu_iq_sva.sv ====
module lsu_iq_sva
    import lsu_iq_pkg::*;
(
    input logic       clk,
    input logic       arst_n_i,
    input logic       flush_i,
    input logic [1:0] disp_valid_i,
    input logic       disp_ready_o,
    input logic       req_valid_o,
    input logic       req_ready_i,
    input mem_op_e    req_op_o,
    input mem_size_e  req_size_o,
    input word_t      req_vaddr_o,
    input word_t      req_wdata_o,
    input byte_mask_t req_strb_o,
    input byte_mask_t req_rmask_o,
    input rob_id_t    req_rob_id_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // dispatch only while room is advertised
    assert property (@(posedge clk) disable iff (!arst_n_i) (|disp_valid_i) |-> disp_ready_o)
        else $error("dispatch valid while disp_ready_o low");

    // stalled request holds
    assert property (@(posedge clk) disable iff (!arst_n_i)
        (req_valid_o && !req_ready_i && !flush_i) |=> (req_valid_o
        && $stable(req_op_o) && $stable(req_size_o)
        && $stable(req_vaddr_o) && $stable(req_wdata_o)
        && $stable(req_strb_o) && $stable(req_rmask_o) && $stable(req_rob_id_o)))
        else $error("request changed while stalled");

    assert property (@(posedge clk) disable iff (!arst_n_i) flush_i |=> !req_valid_o)
        else $error("request valid after flush");

    assert property (@(posedge clk) $rose(arst_n_i) |-> !req_valid_o)
        else $error("request valid after reset");

endmodule

bind lsu_iq lsu_iq_sva lsu_iq_sva_inst (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .flush_i      (flush_i),
    .disp_valid_i (disp_valid_i),
    .disp_ready_o (disp_ready_o),
    .req_valid_o  (req_valid_o),
    .req_ready_i  (req_ready_i),
    .req_op_o     (req_op_o),
    .req_size_o   (req_size_o),
    .req_vaddr_o  (req_vaddr_o),
    .req_wdata_o  (req_wdata_o),
    .req_strb_o   (req_strb_o),
    .req_rmask_o  (req_rmask_o),
    .req_rob_id_o (req_rob_id_o)
);

// ==== hw/lsu_iq.sv ====
`include "lsu_iq_consts.svh"

module lsu_iq
    import lsu_iq_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      flush_i,
    // dispatch, source 0 is store data and source 1 the address
    input  logic [1:0]                disp_valid_i,
    input  mem_op_e                   disp_op_i     [2],
    input  mem_size_e                 disp_size_i   [2],
    input  word_t                     disp_imm_i    [2],
    input  rob_id_t                   disp_rob_id_i [2],
    input  word_t                     src_data_i    [2][2],
    input  rob_id_t                   src_tag_i     [2][2],
    input  logic                      src_rdy_i     [2][2],
    output logic                      disp_ready_o,
    // CDB
    input  logic [`LSU_CDB_COUNT-1:0] cdb_valid_i,
    input  rob_id_t                   cdb_tag_i     [`LSU_CDB_COUNT],
    input  word_t                     cdb_data_i    [`LSU_CDB_COUNT],
    // cache request
    output logic                      req_valid_o,
    input  logic                      req_ready_i,
    output mem_op_e                   req_op_o,
    output mem_size_e                 req_size_o,
    output word_t                     req_vaddr_o,
    output word_t                     req_wdata_o,
    output byte_mask_t                req_strb_o,
    output byte_mask_t                req_rmask_o,
    output rob_id_t                   req_rob_id_o
);

    logic         entry_init    [`LSU_IQ_SIZE];
    logic         entry_slot    [`LSU_IQ_SIZE];
    logic         entry_release [`LSU_IQ_SIZE];
    logic         issue_fire;
    entry_state_e entry_state   [`LSU_IQ_SIZE];
    mem_op_e      entry_op      [`LSU_IQ_SIZE];
    mem_size_e    entry_size    [`LSU_IQ_SIZE];
    word_t        entry_imm     [`LSU_IQ_SIZE];
    rob_id_t      entry_rob_id  [`LSU_IQ_SIZE];
    word_t        entry_data    [`LSU_IQ_SIZE][2];

    // --------------------
    // tail side
    lsu_iq_alloc lsu_iq_alloc_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .disp_valid_i (disp_valid_i),
        .issue_fire_i (issue_fire),
        .disp_ready_o (disp_ready_o),
        .entry_init_o (entry_init),
        .entry_slot_o (entry_slot)
    );

    // --------------------
    // entry ring
    for (genvar i = 0; i < `LSU_IQ_SIZE; i++) begin : gen_entry
        iq_entry iq_entry_inst (
            .clk           (clk),
            .arst_n_i      (arst_n_i),
            .flush_i       (flush_i),
            .init_i        (entry_init[i]),
            .slot_i        (entry_slot[i]),
            .release_i     (entry_release[i]),
            .disp_op_i     (disp_op_i),
            .disp_size_i   (disp_size_i),
            .disp_imm_i    (disp_imm_i),
            .disp_rob_id_i (disp_rob_id_i),
            .src_data_i    (src_data_i),
            .src_tag_i     (src_tag_i),
            .src_rdy_i     (src_rdy_i),
            .cdb_valid_i   (cdb_valid_i),
            .cdb_tag_i     (cdb_tag_i),
            .cdb_data_i    (cdb_data_i),
            .state_o       (entry_state[i]),
            .op_o          (entry_op[i]),
            .size_o        (entry_size[i]),
            .imm_o         (entry_imm[i]),
            .rob_id_o      (entry_rob_id[i]),
            .data_o        (entry_data[i])
        );
    end

    // --------------------
    // head side and request
    lsu_iq_issue lsu_iq_issue_inst (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .req_ready_i     (req_ready_i),
        .entry_state_i   (entry_state),
        .entry_op_i      (entry_op),
        .entry_size_i    (entry_size),
        .entry_imm_i     (entry_imm),
        .entry_rob_id_i  (entry_rob_id),
        .entry_data_i    (entry_data),
        .entry_release_o (entry_release),
        .issue_fire_o    (issue_fire),
        .req_valid_o     (req_valid_o),
        .req_op_o        (req_op_o),
        .req_size_o      (req_size_o),
        .req_vaddr_o     (req_vaddr_o),
        .req_wdata_o     (req_wdata_o),
        .req_strb_o      (req_strb_o),
        .req_rmask_o     (req_rmask_o),
        .req_rob_id_o    (req_rob_id_o)
    );

endmodule

// ==== hw/lsu_iq_issue.sv ====
`include "lsu_iq_consts.svh"

module lsu_iq_issue
    import lsu_iq_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n_i,
    input  logic         flush_i,
    input  logic         req_ready_i,
    input  entry_state_e entry_state_i  [`LSU_IQ_SIZE],
    input  mem_op_e      entry_op_i     [`LSU_IQ_SIZE],
    input  mem_size_e    entry_size_i   [`LSU_IQ_SIZE],
    input  word_t        entry_imm_i    [`LSU_IQ_SIZE],
    input  rob_id_t      entry_rob_id_i [`LSU_IQ_SIZE],
    input  word_t        entry_data_i   [`LSU_IQ_SIZE][2],
    output logic         entry_release_o [`LSU_IQ_SIZE],
    output logic         issue_fire_o,
    output logic         req_valid_o,
    output mem_op_e      req_op_o,
    output mem_size_e    req_size_o,
    output word_t        req_vaddr_o,
    output word_t        req_wdata_o,
    output byte_mask_t   req_strb_o,
    output byte_mask_t   req_rmask_o,
    output rob_id_t      req_rob_id_o
);

    logic [`LSU_IQ_PTR_W-1:0] head_q;
    logic                     head_ready;
    logic                     reg_free;
    logic                     fire;
    word_t                    head_vaddr;
    byte_mask_t               size_mask;

    // --------------------
    // in order select at the head

    // only the oldest entry may leave, a younger ready one waits behind it
    assign head_ready = (entry_state_i[head_q] == ENTRY_READY);
    assign reg_free   = !req_valid_o || req_ready_i;
    assign fire       = head_ready && reg_free && !flush_i;

    // operand 1 is the base address
    assign head_vaddr = entry_data_i[head_q][1] + entry_imm_i[head_q];

    assign issue_fire_o = fire;

    always_comb begin
        for (int i = 0; i < `LSU_IQ_SIZE; i++) begin
            entry_release_o[i] = fire && (head_q == i[`LSU_IQ_PTR_W-1:0]);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q <= '0;
        end else if (flush_i) begin
            head_q <= '0;
        end else if (fire) begin
            head_q <= head_q + 1'b1;
        end
    end

    // --------------------
    // issue register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_valid_o <= 1'b0;
        end else if (flush_i) begin
            // held request is dropped too
            req_valid_o <= 1'b0;
        end else if (reg_free) begin
            req_valid_o <= head_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            req_op_o     <= entry_op_i[head_q];
            req_size_o   <= entry_size_i[head_q];
            req_rob_id_o <= entry_rob_id_i[head_q];
            req_wdata_o  <= entry_data_i[head_q][0];
            req_vaddr_o  <= head_vaddr;
        end
    end

    // --------------------
    // byte lanes from size and low address bits
    always_comb begin
        case (req_size_o)
            SIZE_BYTE: size_mask = 4'b0001 << req_vaddr_o[1:0];
            SIZE_HALF: size_mask = 4'b0011 << {req_vaddr_o[1], 1'b0};
            default:   size_mask = 4'b1111;
        endcase
    end

    // stores drive the strobe, loads the read mask
    assign req_strb_o  = (req_op_o == MEM_STORE) ? size_mask : 4'b0000;
    assign req_rmask_o = (req_op_o == MEM_LOAD) ? size_mask : 4'b0000;

endmodule

// ==== hw/iq_entry.sv ====
`include "lsu_iq_consts.svh"

module iq_entry
    import lsu_iq_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      flush_i,
    input  logic                      init_i,
    input  logic                      slot_i,
    input  logic                      release_i,
    input  mem_op_e                   disp_op_i     [2],
    input  mem_size_e                 disp_size_i   [2],
    input  word_t                     disp_imm_i    [2],
    input  rob_id_t                   disp_rob_id_i [2],
    input  word_t                     src_data_i    [2][2],
    input  rob_id_t                   src_tag_i     [2][2],
    input  logic                      src_rdy_i     [2][2],
    input  logic [`LSU_CDB_COUNT-1:0] cdb_valid_i,
    input  rob_id_t                   cdb_tag_i     [`LSU_CDB_COUNT],
    input  word_t                     cdb_data_i    [`LSU_CDB_COUNT],
    output entry_state_e              state_o,
    output mem_op_e                   op_o,
    output mem_size_e                 size_o,
    output word_t                     imm_o,
    output rob_id_t                   rob_id_o,
    output word_t                     data_o        [2]
);

    entry_state_e state_q;
    entry_state_e state_d;
    word_t        data_q [2];
    word_t        data_d [2];
    rob_id_t      tag_q  [2];
    rob_id_t      tag_d  [2];
    logic [1:0]   rdy_q;
    logic [1:0]   rdy_d;

    // --------------------
    // operand capture and CDB snoop

    // on init the candidate comes from the dispatch slot, so a CDB hit in the
    // same cycle is folded in as well
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            if (init_i) begin
                data_d[s] = src_data_i[slot_i][s];
                tag_d[s]  = src_tag_i[slot_i][s];
                rdy_d[s]  = src_rdy_i[slot_i][s];
            end else begin
                data_d[s] = data_q[s];
                tag_d[s]  = tag_q[s];
                rdy_d[s]  = rdy_q[s];
            end
            for (int c = 0; c < `LSU_CDB_COUNT; c++) begin
                if (!rdy_d[s] && cdb_valid_i[c] && (cdb_tag_i[c] == tag_d[s])) begin
                    data_d[s] = cdb_data_i[c];
                    rdy_d[s]  = 1'b1;
                end
            end
        end
    end

    // --------------------
    // entry FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            ENTRY_FREE: begin
                if (init_i) begin
                    state_d = (&rdy_d) ? ENTRY_READY : ENTRY_WAIT;
                end
            end
            ENTRY_WAIT: begin
                if (&rdy_d) begin
                    state_d = ENTRY_READY;
                end
            end
            ENTRY_READY: begin
                if (release_i) begin
                    state_d = ENTRY_FREE;
                end
            end
            default: state_d = ENTRY_FREE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ENTRY_FREE;
            rdy_q   <= '0;
        end else if (flush_i) begin
            state_q <= ENTRY_FREE;
            rdy_q   <= '0;
        end else begin
            state_q <= state_d;
            rdy_q   <= rdy_d;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        data_q <= data_d;
        tag_q  <= tag_d;
        if (init_i) begin
            op_o     <= disp_op_i[slot_i];
            size_o   <= disp_size_i[slot_i];
            imm_o    <= disp_imm_i[slot_i];
            rob_id_o <= disp_rob_id_i[slot_i];
        end
    end

    assign state_o = state_q;
    assign data_o  = data_q;

endmodule

// ==== hw/lsu_iq_alloc.sv ====
`include "lsu_iq_consts.svh"

module lsu_iq_alloc (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       flush_i,
    input  logic [1:0] disp_valid_i,
    input  logic       issue_fire_i,
    output logic       disp_ready_o,
    output logic       entry_init_o [`LSU_IQ_SIZE],
    output logic       entry_slot_o [`LSU_IQ_SIZE]
);

    // free count has to reach LSU_IQ_SIZE itself
    localparam int CNT_W = `LSU_IQ_PTR_W + 1;

    logic [`LSU_IQ_PTR_W-1:0] tail_q;
    logic [`LSU_IQ_PTR_W-1:0] tail_p1;
    logic [`LSU_IQ_PTR_W-1:0] tail_d;
    logic [CNT_W-1:0]         free_cnt_q;
    logic [CNT_W-1:0]         free_cnt_d;
    logic [1:0]               accept;
    logic [1:0]               n_acc;

    // --------------------
    // accepted dispatch slots

    // slots count only while ready is advertised and no flush is pending
    assign accept = flush_i ? 2'b00 : (disp_valid_i & {2{disp_ready_o}});
    assign n_acc  = {1'b0, accept[0]} + {1'b0, accept[1]};

    assign tail_p1 = tail_q + 1'b1;
    assign tail_d  = tail_q + n_acc;

    // one slot leaves per issue
    assign free_cnt_d = free_cnt_q - CNT_W'(n_acc) + CNT_W'(issue_fire_i);

    // --------------------
    // per entry write strobes with slot compaction
    always_comb begin
        for (int i = 0; i < `LSU_IQ_SIZE; i++) begin
            entry_init_o[i] = ((tail_q == i[`LSU_IQ_PTR_W-1:0]) && (|accept))
                           || ((tail_p1 == i[`LSU_IQ_PTR_W-1:0]) && (&accept));
            // tail takes slot 1 only when slot 0 is idle
            if (tail_q == i[`LSU_IQ_PTR_W-1:0]) begin
                entry_slot_o[i] = !accept[0];
            end else begin
                entry_slot_o[i] = 1'b1;
            end
        end
    end

    // --------------------
    // pointer, count and ready level
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tail_q       <= '0;
            free_cnt_q   <= CNT_W'(`LSU_IQ_SIZE);
            disp_ready_o <= 1'b1;
        end else if (flush_i) begin
            tail_q       <= '0;
            free_cnt_q   <= CNT_W'(`LSU_IQ_SIZE);
            disp_ready_o <= 1'b1;
        end else begin
            tail_q       <= tail_d;
            free_cnt_q   <= free_cnt_d;
            // room for a full dispatch pair next cycle
            disp_ready_o <= (free_cnt_d >= CNT_W'(2));
        end
    end

endmodule

// ==== hw/lsu_iq_pkg.sv ====
`include "lsu_iq_consts.svh"

package lsu_iq_pkg;

    // data or address word
    typedef logic [`LSU_WORD_W-1:0] word_t;

    // reorder buffer tag
    typedef logic [`LSU_ROB_ID_W-1:0] rob_id_t;

    typedef enum logic {
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_e;

    // free -> wait -> ready -> free
    typedef enum logic [1:0] {
        ENTRY_FREE,
        ENTRY_WAIT,
        ENTRY_READY
    } entry_state_e;

    // store strobe or load read mask, one bit per byte lane
    typedef logic [3:0] byte_mask_t;

endpackage

// ==== hw/lsu_iq_consts.svh ====
`ifndef LSU_IQ_CONSTS_SVH
`define LSU_IQ_CONSTS_SVH

// queue geometry, depth must stay a power of two
`define LSU_IQ_SIZE     8
`define LSU_IQ_PTR_W    3

// datapath widths
`define LSU_WORD_W      32
`define LSU_ROB_ID_W    6

// number of result broadcast ports on the CDB
`define LSU_CDB_COUNT   2

`endif
